/* Makefile */
# Verilator simulation of the platform top level

VERILATOR ?= verilator
TOP       ?= tb_sys_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(BUILD_DIR)/sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass/fail from $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src.f */
verilog/sys_pkg.sv
verilog/host_cmd_decoder.sv
verilog/audio_mixer.sv
verilog/sync_polarity.sv
verilog/vga_sync_out.sv
verilog/sys_top.sv
verification/tb_sys_top.sv

/* verification/tb_sys_top.sv */
/*
 * Testbench for the platform top level
 * Random host frames, audio streams under back-pressure and
 * sync waveforms, checked against models kept here
 */

`timescale 1ns/1ps

module tb_sys_top;
	import sys_pkg::*;

	logic        clk_sys;
	logic        resetd;
	host_word_t  i_host;
	logic        i_host_valid;
	logic        o_host_ack;
	audio_pair_t i_audio;
	logic        i_audio_signed;
	mix_mode_t   i_audio_mix;
	logic        i_audio_valid;
	logic        o_audio_ready;
	audio_pair_t o_audio;
	logic        o_audio_valid;
	logic        i_audio_ready;
	logic        i_hs;
	logic        i_vs;
	logic        o_vga_hs;
	logic        o_vga_vs;

	logic [31:0] seed = 32'h4c81;
	sys_cfg_t    m_cfg;
	vol_att_t    m_vol;
	logic        m_has_cmd;
	logic [7:0]  m_cmd;
	audio_pair_t exp_q[$];
	logic        m_s1_valid;
	logic        m_s2_valid;
	logic        in_fired;
	logic        sync_run;
	logic        sync_check;
	logic        hs_low;
	logic        vs_low;
	int          hs_period, hs_pulse, hs_pos;
	int          vs_period, vs_pulse, vs_pos;

	sys_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Random numbers and reference models
	// ============================================================

	function automatic int rand_below(input int n);
		seed = seed * 32'd1664525 + 32'd1013904223;
		return int'(seed[30:16]) % n;
	endfunction

	function automatic logic [15:0] rand_word();
		return {8'(rand_below(256)), 8'(rand_below(256))};
	endfunction

	// Arithmetic for signed samples, logical otherwise
	function automatic logic [15:0] shift_down(input logic [15:0] w, input int n,
			input logic sgn);
		logic signed [15:0] sw;
		sw = w;
		if (sgn) begin
			return sw >>> n;
		end
		return w >> n;
	endfunction

	function automatic logic [15:0] crossfeed(input logic [15:0] own,
			input logic [15:0] other, input mix_mode_t m, input logic sgn);
		int k;
		if (m == MIX_NONE) begin
			return own;
		end
		if (m == MIX_HALF) begin
			return shift_down(own, 1, sgn) + shift_down(other, 1, sgn);
		end
		k = (m == MIX_EIGHTH) ? 3 : 2;
		return own - shift_down(own, k, sgn) + shift_down(other, k, sgn);
	endfunction

	function automatic audio_pair_t expect_pair(input audio_pair_t x, input logic sgn,
			input mix_mode_t m, input vol_att_t v);
		audio_pair_t y;
		y.l.u = crossfeed(x.l.u, x.r.u, m, sgn);
		y.r.u = crossfeed(x.r.u, x.l.u, m, sgn);
		y.l.u = v.mute ? 16'h0 : shift_down(y.l.u, int'(v.shift), sgn);
		y.r.u = v.mute ? 16'h0 : shift_down(y.r.u, int'(v.shift), sgn);
		return y;
	endfunction

	// ============================================================
	// Checks
	// ============================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_audio(input audio_pair_t got, input audio_pair_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch at %0t: o_audio got %h, expected %h",
				$time, got, exp));
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch at %0t: o_host_ack got %b, expected %b",
				$time, got, exp));
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch at %0t: %s got %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	// ============================================================
	// Stimulus
	// ============================================================

	task automatic advance_sync();
		hs_pos = (hs_pos + 1) % hs_period;
		vs_pos = (vs_pos + 1) % vs_period;
		i_hs = (hs_pos < hs_pulse) ^ hs_low;
		i_vs = (vs_pos < vs_pulse) ^ vs_low;
	endtask

	// One clock; inputs were driven at the falling edge just before
	task automatic tick();
		logic host_acc;
		logic hs_ah;
		logic vs_ah;
		logic exp_hs;
		logic exp_vs;
		logic exp_rdy;
		#1;
		host_acc = i_host_valid;
		hs_ah = i_hs ^ hs_low;
		vs_ah = i_vs ^ vs_low;
		exp_hs = m_cfg.csync ? ~(hs_ah ^ vs_ah) : ~hs_ah;
		exp_vs = m_cfg.csync ? 1'b1 : ~vs_ah;
		if (!i_host.frame) begin
			m_has_cmd = 1'b0;
		end else if (i_host_valid && !m_has_cmd) begin
			m_cmd = i_host.data[7:0];
			m_has_cmd = 1'b1;
		end else if (i_host_valid && m_cmd == cmd_cfg) begin
			m_cfg = sys_cfg_t'(i_host.data);
		end else if (i_host_valid && m_cmd == cmd_volume) begin
			m_vol = vol_att_t'(i_host.data[4:0]);
		end
		// Pipe stalls only when stage 2 is full and the consumer holds off
		exp_rdy = !m_s2_valid || i_audio_ready;
		check_level("o_audio_ready", o_audio_ready, exp_rdy);
		check_level("o_audio_valid", o_audio_valid, m_s2_valid);
		// Output side first since it holds the older sample
		if (m_s2_valid && i_audio_ready) begin
			if (exp_q.size() == 0) begin
				abort_run("Audio output was taken while no sample was in flight");
			end else begin
				check_audio(o_audio, exp_q.pop_front());
			end
		end
		in_fired = i_audio_valid && exp_rdy;
		if (in_fired) begin
			exp_q.push_back(expect_pair(i_audio, i_audio_signed, i_audio_mix, m_vol));
		end
		if (exp_rdy) begin
			m_s2_valid = m_s1_valid;
			m_s1_valid = i_audio_valid;
		end
		@(negedge clk_sys);
		check_ack(o_host_ack, host_acc);
		if (sync_check) begin
			check_level("o_vga_hs", o_vga_hs, exp_hs);
			check_level("o_vga_vs", o_vga_vs, exp_vs);
		end
		if (sync_run) begin
			advance_sync();
		end
	endtask

	task automatic send_word(input logic [15:0] data);
		i_host.frame = 1'b1;
		i_host.data = data;
		i_host_valid = 1'b1;
		tick();
		i_host_valid = 1'b0;
		repeat (rand_below(3)) tick();
	endtask

	// Command word, one chosen payload word, then random extra words
	task automatic send_frame(input logic [7:0] cmd, input logic [15:0] payload,
			input int n_extra);
		send_word({8'(rand_below(256)), cmd});
		send_word(payload);
		repeat (n_extra) send_word(rand_word());
		i_host.frame = 1'b0;
		repeat (1 + rand_below(2)) tick();
	endtask

	task automatic stream_audio(input int n);
		int sent;
		int cycles;
		sent = 0;
		cycles = 0;
		while (sent < n || (i_audio_valid && !in_fired) || exp_q.size() != 0) begin
			if (!i_audio_valid || in_fired) begin
				i_audio_valid = 1'b0;
				if (sent < n && rand_below(4) != 0) begin
					i_audio.l.u = rand_word();
					i_audio.r.u = rand_word();
					i_audio_signed = 1'(rand_below(2));
					i_audio_mix = mix_mode_t'(rand_below(4));
					i_audio_valid = 1'b1;
					sent++;
				end
			end
			i_audio_ready = rand_below(4) != 0;
			tick();
			cycles++;
			if (cycles > 50 * n) begin
				abort_run("Timeout while waiting for the audio stream to drain");
			end
		end
		i_audio_valid = 1'b0;
		i_audio_ready = 1'b1;
	endtask

	task automatic start_sync();
		hs_period = 8 + rand_below(16);
		hs_pulse = 1 + rand_below(hs_period / 2 - 1);
		vs_period = 40 + rand_below(40);
		vs_pulse = 1 + rand_below(8);
		hs_low = 1'(rand_below(2));
		vs_low = 1'(rand_below(2));
		hs_pos = 0;
		vs_pos = 0;
		i_hs = 1'b1 ^ hs_low;
		i_vs = 1'b1 ^ vs_low;
		sync_run = 1'b1;
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		sys_cfg_t   cfg_word;
		logic [7:0] cmd;
		resetd = 1'b1;
		i_host = '0;
		i_host_valid = 1'b0;
		i_audio = '0;
		i_audio_signed = 1'b0;
		i_audio_mix = MIX_NONE;
		i_audio_valid = 1'b0;
		i_audio_ready = 1'b1;
		i_hs = 1'b0;
		i_vs = 1'b0;
		m_cfg = '0;
		m_vol = '0;
		m_has_cmd = 1'b0;
		m_cmd = 8'h0;
		m_s1_valid = 1'b0;
		m_s2_valid = 1'b0;
		in_fired = 1'b0;
		sync_run = 1'b0;
		sync_check = 1'b0;
		hs_low = 1'b0;
		vs_low = 1'b0;
		repeat (10) @(negedge clk_sys);
		check_ack(o_host_ack, 1'b0);
		check_level("o_audio_valid", o_audio_valid, 1'b0);
		check_level("o_vga_hs", o_vga_hs, 1'b1);
		check_level("o_vga_vs", o_vga_vs, 1'b1);
		resetd = 1'b0;

		repeat (30) begin
			case (rand_below(3))
				0: cmd = cmd_cfg;
				1: cmd = cmd_volume;
				default: cmd = 8'(rand_below(256));
			endcase
			send_frame(cmd, rand_word(), rand_below(3));
		end

		// Volume left behind by the random frames
		stream_audio(20);

		// New volume before each batch of samples
		repeat (8) begin
			send_frame(cmd_volume,
				{11'(rand_below(2048)), rand_below(5) == 0, 4'(rand_below(16))}, 0);
			stream_audio(40);
		end

		// Separate sync first, then composite
		for (int r = 0; r < 2; r++) begin
			sync_check = 1'b0;
			cfg_word = sys_cfg_t'(rand_word());
			cfg_word.csync = 1'(r);
			send_frame(cmd_cfg, cfg_word, 0);
			start_sync();
			repeat (2 * vs_period + 6) tick();
			sync_check = 1'b1;
			repeat (3 * vs_period) tick();
		end

		$display("Everything OK");
		$finish;
	end

endmodule

/* verilog/audio_mixer.sv */
/*
 * Stereo audio mixer
 * Stage 1 applies crossfeed between channels, stage 2 applies
 * mute and volume attenuation; valid/ready on both sides
 */

`timescale 1ns/1ps

module audio_mixer #(
	parameter int SAMPLE_W = sys_pkg::SAMPLE_W
) (
	input  logic                 clk_sys,
	input  logic                 resetd,

	input  sys_pkg::audio_pair_t i_audio,
	input  logic                 i_audio_signed,
	input  sys_pkg::mix_mode_t   i_audio_mix,
	input  logic                 i_audio_valid,
	output logic                 o_audio_ready,

	input  sys_pkg::vol_att_t    i_vol,

	output sys_pkg::audio_pair_t o_audio,
	output logic                 o_audio_valid,
	input  logic                 i_audio_ready
);
	import sys_pkg::*;

	typedef logic [SAMPLE_W-1:0] word_t;

	// Arithmetic shift for signed samples, logical for unsigned
	function automatic word_t shr(input audio_sample_u v, input logic [3:0] amt,
			input logic sgn);
		if (sgn) begin
			return v.s >>> amt;
		end
		return v.u >> amt;
	endfunction

	// Own channel minus its share plus the same share of the other one
	function automatic word_t mix_ch(input audio_sample_u own_ch,
			input audio_sample_u cross_ch, input mix_mode_t mode, input logic sgn);
		word_t own;
		own = own_ch.u;
		case (mode)
			MIX_EIGHTH:  return own - shr(own_ch, 4'd3, sgn) + shr(cross_ch, 4'd3, sgn);
			MIX_QUARTER: return own - shr(own_ch, 4'd2, sgn) + shr(cross_ch, 4'd2, sgn);
			MIX_HALF:    return shr(own_ch, 4'd1, sgn) + shr(cross_ch, 4'd1, sgn);
			default:     return own;
		endcase
	endfunction

	function automatic word_t atten(input audio_sample_u v, input vol_att_t vol,
			input logic sgn);
		if (vol.mute) begin
			return '0;
		end
		return shr(v, vol.shift, sgn);
	endfunction

	audio_pair_t mix_pair;
	audio_pair_t att_pair;
	audio_pair_t s1_pair;
	logic        s1_signed;
	logic        s1_valid;

	// ============================================================
	// Datapath
	// ============================================================

	always_comb begin
		mix_pair.l.u = mix_ch(i_audio.l, i_audio.r, i_audio_mix, i_audio_signed);
		mix_pair.r.u = mix_ch(i_audio.r, i_audio.l, i_audio_mix, i_audio_signed);

		// Volume sampled as the word moves into stage 2
		att_pair.l.u = atten(s1_pair.l, i_vol, s1_signed);
		att_pair.r.u = atten(s1_pair.r, i_vol, s1_signed);
	end

	// ============================================================
	// Pipeline control
	// ============================================================

	// Whole pipe moves unless the output holds a word nobody takes
	assign o_audio_ready = ~o_audio_valid | i_audio_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1_valid      <= 1'b0;
			o_audio_valid <= 1'b0;
		end else if (o_audio_ready) begin
			s1_valid      <= i_audio_valid;
			o_audio_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (o_audio_ready) begin
			s1_pair   <= mix_pair;
			s1_signed <= i_audio_signed;
			o_audio   <= att_pair;
		end
	end

endmodule

/* verilog/host_cmd_decoder.sv */
/*
 * Host command decoder
 * Parses framed 16-bit host words into a command byte and payload,
 * keeps the configuration and volume registers
 */

`timescale 1ns/1ps

module host_cmd_decoder (
	input  logic                clk_sys,
	input  logic                resetd,

	input  sys_pkg::host_word_t i_host,
	input  logic                i_host_valid,
	output logic                o_host_ack,

	output sys_pkg::sys_cfg_t   o_cfg,
	output sys_pkg::vol_att_t   o_vol
);
	import sys_pkg::*;

	logic       frame_q;
	logic       frame_end;
	logic       has_cmd;
	logic [7:0] cmd;
	logic       payload_we;

	// ============================================================
	// Frame tracking
	// ============================================================

	// Select dropping closes the current frame
	assign frame_end = frame_q & ~i_host.frame;

	// Accepted word inside a frame after the command byte
	assign payload_we = i_host_valid & i_host.frame & has_cmd;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			frame_q    <= 1'b0;
			has_cmd    <= 1'b0;
			o_host_ack <= 1'b0;
		end else begin
			frame_q    <= i_host.frame;
			// Every accepted word is acknowledged next cycle
			o_host_ack <= i_host_valid;

			if (frame_end) begin
				has_cmd <= 1'b0;
			end else if (i_host_valid && i_host.frame && !has_cmd) begin
				has_cmd <= 1'b1;
			end
		end
	end

	// First word of a frame carries the command in its low byte
	always_ff @(posedge clk_sys) begin
		if (i_host_valid && i_host.frame && !has_cmd) begin
			cmd <= i_host.data[7:0];
		end
	end

	// ============================================================
	// Payload registers
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_cfg <= '0;
			o_vol <= '0;
		end else if (payload_we) begin
			case (cmd)
				cmd_cfg: begin
					o_cfg <= sys_cfg_t'(i_host.data);
				end
				cmd_volume: begin
					// Only the low five bits are meaningful
					o_vol <= vol_att_t'(i_host.data[4:0]);
				end
				default: begin
					// Unknown commands are dropped
				end
			endcase
		end
	end

endmodule

/* verilog/sync_polarity.sv */
/*
 * Sync polarity normalizer
 * Measures high and low phase lengths and inverts the sync
 * so that the short phase is always active high
 */

`timescale 1ns/1ps

module sync_polarity #(
	parameter int CNT_W = 16
) (
	input  logic clk_sys,
	input  logic resetd,

	input  logic i_sync,
	output logic o_sync
);

	logic             sync_meta;
	logic             sync_q;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] hi_len;
	logic [CNT_W-1:0] lo_len;
	logic             pol_flag;

	// Raw input, flipped when the long phase is high
	assign o_sync = i_sync ^ pol_flag;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_meta <= 1'b0;
			sync_q    <= 1'b0;
			cnt       <= '0;
			hi_len    <= '0;
			lo_len    <= '0;
			pol_flag  <= 1'b0;
		end else begin
			sync_meta <= i_sync;
			sync_q    <= sync_meta;

			// Rising edge closes a low phase, falling edge a high one
			if (sync_meta & ~sync_q) lo_len <= cnt;
			if (~sync_meta & sync_q) hi_len <= cnt;

			if (sync_meta != sync_q) begin
				cnt <= '0;
			end else if (~&cnt) begin
				cnt <= cnt + 1'b1;
			end

			pol_flag <= hi_len > lo_len;
		end
	end

endmodule

/* verilog/sys_pkg.sv */
/*
 * Shared platform definitions
 * Host bus beat, decoded configuration and volume words,
 * audio sample and channel pair types, command codes
 */

package sys_pkg;

	// ============================================================
	// Host command channel
	// ============================================================

	typedef struct packed {
		logic        frame;
		logic [15:0] data;
	} host_word_t;

	localparam logic [7:0] cmd_cfg    = 8'h01;
	localparam logic [7:0] cmd_volume = 8'h26;

	// Configuration word, bit positions as sent by the host
	typedef struct packed {
		logic [7:0] rsvd_hi;
		logic       dvi_mode;
		logic       audio_96k;
		logic       ypbpr_en;
		logic       rsvd_4;
		logic       csync;
		logic       vga_scaler;
		logic [1:0] rsvd_lo;
	} sys_cfg_t;

	// Mute in bit 4, right shift amount below it
	typedef struct packed {
		logic       mute;
		logic [3:0] shift;
	} vol_att_t;

	// ============================================================
	// Audio
	// ============================================================

	localparam int SAMPLE_W = 16;

	// Same bits, read as signed or unsigned by the sample flag
	typedef union packed {
		logic signed [SAMPLE_W-1:0] s;
		logic        [SAMPLE_W-1:0] u;
	} audio_sample_u;

	typedef struct packed {
		audio_sample_u l;
		audio_sample_u r;
	} audio_pair_t;

	// Crossfeed strength
	typedef enum logic [1:0] {
		MIX_NONE    = 2'd0,
		MIX_EIGHTH  = 2'd1,
		MIX_QUARTER = 2'd2,
		MIX_HALF    = 2'd3
	} mix_mode_t;

endpackage

/* verilog/sys_top.sv */
/*
 * Platform top level
 * Host command decoder, stereo mixer, sync polarity
 * normalizers and the analog sync output stage
 */

`timescale 1ns/1ps

module sys_top #(
	parameter int SAMPLE_W = sys_pkg::SAMPLE_W,
	parameter int CNT_W    = 16
) (
	input  logic                 clk_sys,
	input  logic                 resetd,

	input  sys_pkg::host_word_t  i_host,
	input  logic                 i_host_valid,
	output logic                 o_host_ack,

	input  sys_pkg::audio_pair_t i_audio,
	input  logic                 i_audio_signed,
	input  sys_pkg::mix_mode_t   i_audio_mix,
	input  logic                 i_audio_valid,
	output logic                 o_audio_ready,
	output sys_pkg::audio_pair_t o_audio,
	output logic                 o_audio_valid,
	input  logic                 i_audio_ready,

	input  logic                 i_hs,
	input  logic                 i_vs,
	output logic                 o_vga_hs,
	output logic                 o_vga_vs
);
	import sys_pkg::*;

	sys_cfg_t cfg;
	vol_att_t vol;
	logic     hs_norm;
	logic     vs_norm;

	// ============================================================
	// Host control
	// ============================================================

	host_cmd_decoder u_host_cmd_decoder (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_host       (i_host),
		.i_host_valid (i_host_valid),
		.o_host_ack   (o_host_ack),
		.o_cfg        (cfg),
		.o_vol        (vol)
	);

	// ============================================================
	// Audio
	// ============================================================

	audio_mixer #(
		.SAMPLE_W (SAMPLE_W)
	) u_audio_mixer (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_audio        (i_audio),
		.i_audio_signed (i_audio_signed),
		.i_audio_mix    (i_audio_mix),
		.i_audio_valid  (i_audio_valid),
		.o_audio_ready  (o_audio_ready),
		.i_vol          (vol),
		.o_audio        (o_audio),
		.o_audio_valid  (o_audio_valid),
		.i_audio_ready  (i_audio_ready)
	);

	// ============================================================
	// Video sync
	// ============================================================

	sync_polarity #(.CNT_W(CNT_W)) hs_polarity (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (hs_norm)
	);

	sync_polarity #(.CNT_W(CNT_W)) vs_polarity (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (vs_norm)
	);

	vga_sync_out u_vga_sync_out (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_hs     (hs_norm),
		.i_vs     (vs_norm),
		.i_csync  (cfg.csync),
		.o_vga_hs (o_vga_hs),
		.o_vga_vs (o_vga_vs)
	);

endmodule

/* verilog/vga_sync_out.sv */
/*
 * Analog VGA sync output stage
 * Separate or composite active-low sync, registered
 */

`timescale 1ns/1ps

module vga_sync_out (
	input  logic clk_sys,
	input  logic resetd,

	// Normalized, active high
	input  logic i_hs,
	input  logic i_vs,
	input  logic i_csync,

	output logic o_vga_hs,
	output logic o_vga_vs
);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			// Both lines idle high
			o_vga_hs <= 1'b1;
			o_vga_vs <= 1'b1;
		end else if (i_csync) begin
			// Composite sync on the hs pin, vs pin parked
			o_vga_hs <= ~(i_hs ^ i_vs);
			o_vga_vs <= 1'b1;
		end else begin
			o_vga_hs <= ~i_hs;
			o_vga_vs <= ~i_vs;
		end
	end

endmodule
